/* Bender.yml */
package:
  name: ntt_lite

export_include_dirs:
  - design

sources:
  - design/ntt_pkg.sv
  - design/pipe_delay.sv
  - design/ntt_butterfly.sv
  - design/ntt_coef_store.sv
  - design/ntt_twiddle_table.sv
  - design/ntt_ctrl_fsm.sv
  - design/ntt_stage_counter.sv
  - design/ntt_top.sv
  - target: test
    files:
      - verification/ntt_sva.sv
      - verification/ntt_tb.sv

/* design/ntt_butterfly.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// gentleman-sande butterfly
// sum = (a+b) mod q, diff = ((a-b) mod q) * w mod q, three cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ntt_params.svh"

module ntt_butterfly import ntt_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  coef_t     a,
    input  coef_t     b,
    input  coef_t     w,
    input  coef_t     q_mod,
    output bfly_out_t res
);

    logic [`NTT_COEF_W:0]     add_full;
    logic [`NTT_COEF_W:0]     sub_full;
    coef_t                    sum_s1;
    coef_t                    diff_s1;
    coef_t                    w_s1;
    logic [2*`NTT_COEF_W-1:0] prod_s2;
    coef_t                    red_s3;

    // modular add and subtract, operands already below q
    always_comb begin
        add_full = {1'b0, a} + {1'b0, b};
        if (add_full >= {1'b0, q_mod})
            add_full = add_full - {1'b0, q_mod};
        if (a >= b)
            sub_full = {1'b0, a} - {1'b0, b};
        else
            sub_full = {1'b0, a} + {1'b0, q_mod} - {1'b0, b};
    end

    always_ff @(posedge clk) begin
        sum_s1  <= add_full[`NTT_COEF_W-1:0];
        diff_s1 <= sub_full[`NTT_COEF_W-1:0];
        w_s1    <= w;
        prod_s2 <= diff_s1 * w_s1;
        // plain remainder; zero until a modulus is loaded
        if (q_mod != '0)
            red_s3 <= coef_t'(prod_s2 % q_mod);
        else
            red_s3 <= '0;
    end

    // sum waits for the multiply and reduce stages
    pipe_delay #(
        .T     (coef_t),
        .DEPTH (`NTT_BFLY_LATENCY - 1)
    ) sum_dly (
        .clk   (clk),
        .reset (reset),
        .d     (sum_s1),
        .q     (res.sum)
    );

    assign res.diff = red_s3;

endmodule

/* design/ntt_coef_store.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// coefficient store
// N-word register array, two registered read ports, two write ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ntt_params.svh"

module ntt_coef_store import ntt_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  addr_t rd_addr0,
    input  addr_t rd_addr1,
    output coef_t rd_data0,
    output coef_t rd_data1,
    input  logic  wr_en0,
    input  logic  wr_en1,
    input  addr_t wr_addr0,
    input  addr_t wr_addr1,
    input  coef_t wr_data0,
    input  coef_t wr_data1
);

    coef_t mem [`NTT_N];

    // butterfly top and bottom never collide, port 1 wins anyway
    always_ff @(posedge clk) begin
        if (wr_en0)
            mem[wr_addr0] <= wr_data0;
        if (wr_en1)
            mem[wr_addr1] <= wr_data1;
    end

    // reads see the array before this edge's writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data0 <= '0;
            rd_data1 <= '0;
        end else begin
            rd_data0 <= mem[rd_addr0];
            rd_data1 <= mem[rd_addr1];
        end
    end

endmodule

/* design/ntt_ctrl_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt control state machine
// sequences twiddle load, data load, compute and unload, and
// raises done for one cycle as the unload begins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ntt_ctrl_fsm import ntt_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_w,
    input  logic       load_data,
    input  logic       start,
    input  logic       phase_last,
    output ntt_state_t state,
    output phase_t     phase,
    output logic       done
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            // end of compute means first unload cycle next
            done <= (state == st_compute) && phase_last;
            case (state)
                st_idle: begin
                    // commands only count here
                    if (load_w)
                        state <= st_load_tw;
                    else if (load_data)
                        state <= st_load_data;
                    else if (start)
                        state <= st_compute;
                end
                st_load_tw, st_load_data: begin
                    if (phase_last)
                        state <= st_idle;
                end
                st_compute: begin
                    if (phase_last)
                        state <= st_unload;
                end
                st_unload: begin
                    if (phase_last)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // counter mode follows the state
    always_comb begin
        case (state)
            st_load_tw:   phase = ph_load_tw;
            st_load_data: phase = ph_load_data;
            st_compute:   phase = ph_bfly;
            st_unload:    phase = ph_unload;
            default:      phase = ph_none;
        endcase
    end

endmodule

/* design/ntt_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt engine parameters
// ring size, word width and butterfly pipeline timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef NTT_PARAMS_SVH
`define NTT_PARAMS_SVH

// ring size and number of stages
`define NTT_N 16
`define NTT_LOG_N 4

// coefficient and modulus width
`define NTT_COEF_W 16

// butterfly pipeline depth in cycles
`define NTT_BFLY_LATENCY 3

// idle gap after each stage
`define NTT_DRAIN `NTT_BFLY_LATENCY

`endif

/* design/ntt_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt package
// shared types for the state machine, counters and data path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ntt_params.svh"

package ntt_pkg;

    typedef logic [`NTT_COEF_W-1:0] coef_t;
    typedef logic [`NTT_LOG_N-1:0] addr_t;
    typedef logic [`NTT_LOG_N-2:0] tw_addr_t;
    typedef logic [$clog2(`NTT_LOG_N)-1:0] stage_t;

    typedef enum logic [2:0] {
        st_idle, st_load_tw, st_load_data, st_compute, st_unload
    } ntt_state_t;

    // counter modes
    typedef enum logic [2:0] {
        ph_none, ph_load_tw, ph_load_data, ph_bfly, ph_unload
    } phase_t;

    typedef struct packed {
        logic     valid;
        addr_t    top;
        addr_t    bot;
        tw_addr_t tw;
    } bfly_cmd_t;

    typedef struct packed {
        logic  we;
        addr_t top;
        addr_t bot;
    } wb_cmd_t;

    typedef struct packed {
        coef_t sum;
        coef_t diff;
    } bfly_out_t;

endpackage

/* design/ntt_stage_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt phase counter
// counts load and unload words, stages and butterflies with their
// drain gap, and derives the butterfly addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ntt_params.svh"

module ntt_stage_counter import ntt_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  phase_t    phase,
    output addr_t     count,
    output logic      phase_last,
    output bfly_cmd_t cmd
);

    // one extra bit, unload runs N+1 cycles
    localparam int CNT_W       = `NTT_LOG_N + 1;
    localparam int LAST_TW     = `NTT_N / 2;
    localparam int LAST_DATA   = `NTT_N - 1;
    localparam int LAST_UNLOAD = `NTT_N;
    localparam int ISSUE       = `NTT_N / 2;
    localparam int LAST_STEP   = `NTT_N / 2 + `NTT_DRAIN - 1;

    logic [CNT_W-1:0] cnt;
    stage_t           stage;
    tw_addr_t         bfly_idx;
    addr_t            half;
    addr_t            low_mask;
    addr_t            top;

    assign count = cnt[`NTT_LOG_N-1:0];

    always_comb begin
        case (phase)
            ph_load_tw:   phase_last = (cnt == CNT_W'(LAST_TW));
            ph_load_data: phase_last = (cnt == CNT_W'(LAST_DATA));
            ph_bfly:      phase_last = (stage == stage_t'(`NTT_LOG_N - 1)) &&
                                       (cnt == CNT_W'(LAST_STEP));
            ph_unload:    phase_last = (cnt == CNT_W'(LAST_UNLOAD));
            default:      phase_last = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt   <= '0;
            stage <= '0;
        end else if (phase == ph_none || phase_last) begin
            cnt   <= '0;
            stage <= '0;
        end else if (phase == ph_bfly && cnt == CNT_W'(LAST_STEP)) begin
            // drain done, next stage
            cnt   <= '0;
            stage <= stage + 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // half span h = N >> (stage+1)
    always_comb begin
        bfly_idx  = cnt[`NTT_LOG_N-2:0];
        half      = addr_t'((`NTT_N / 2) >> stage);
        low_mask  = half - 1'b1;
        top       = ((addr_t'(bfly_idx) & ~low_mask) << 1) | (addr_t'(bfly_idx) & low_mask);
        cmd.valid = (phase == ph_bfly) && (cnt < CNT_W'(ISSUE));
        cmd.top   = top;
        cmd.bot   = top | half;
        cmd.tw    = tw_addr_t'((addr_t'(bfly_idx) & low_mask) << stage);
    end

endmodule

/* design/ntt_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt top
// single butterfly in-place forward NTT, standard order in and
// bit-reversed order out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ntt_params.svh"

module ntt_top import ntt_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  load_w,
    input  logic  load_data,
    input  logic  start,
    input  coef_t din,
    output logic  done,
    output coef_t dout
);

    localparam int RD_LATENCY = 1;

    ntt_state_t state;
    phase_t     phase;
    logic       phase_last;
    addr_t      count;
    bfly_cmd_t  cmd;
    wb_cmd_t    wb_d;
    wb_cmd_t    wb_q;
    addr_t      rd_addr0;
    coef_t      rd_data0;
    coef_t      rd_data1;
    logic       wr_en0;
    addr_t      wr_addr0;
    coef_t      wr_data0;
    coef_t      w;
    coef_t      q_mod;
    bfly_out_t  res;

    ntt_ctrl_fsm ctrl (
        .clk        (clk),
        .reset      (reset),
        .load_w     (load_w),
        .load_data  (load_data),
        .start      (start),
        .phase_last (phase_last),
        .state      (state),
        .phase      (phase),
        .done       (done)
    );

    ntt_stage_counter cntr (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .count      (count),
        .phase_last (phase_last),
        .cmd        (cmd)
    );

    // port 0 is shared by loader, write-back and unload
    always_comb begin
        rd_addr0 = (state == st_unload) ? count : cmd.top;
        if (state == st_load_data) begin
            wr_en0   = 1'b1;
            wr_addr0 = count;
            wr_data0 = din;
        end else begin
            wr_en0   = wb_q.we;
            wr_addr0 = wb_q.top;
            wr_data0 = res.sum;
        end
    end

    ntt_coef_store store (
        .clk      (clk),
        .reset    (reset),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (cmd.bot),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .wr_en0   (wr_en0),
        .wr_en1   (wb_q.we),
        .wr_addr0 (wr_addr0),
        .wr_addr1 (wb_q.bot),
        .wr_data0 (wr_data0),
        .wr_data1 (res.diff)
    );

    ntt_twiddle_table twiddle (
        .clk     (clk),
        .reset   (reset),
        .state   (state),
        .count   (count),
        .din     (din),
        .rd_addr (cmd.tw),
        .w       (w),
        .q_mod   (q_mod)
    );

    ntt_butterfly bfly (
        .clk   (clk),
        .reset (reset),
        .a     (rd_data0),
        .b     (rd_data1),
        .w     (w),
        .q_mod (q_mod),
        .res   (res)
    );

    // write-back addresses ride along with the operands
    assign wb_d = '{we: cmd.valid, top: cmd.top, bot: cmd.bot};

    pipe_delay #(
        .T     (wb_cmd_t),
        .DEPTH (RD_LATENCY + `NTT_BFLY_LATENCY)
    ) wb_dly (
        .clk   (clk),
        .reset (reset),
        .d     (wb_d),
        .q     (wb_q)
    );

    // first unload cycle carries done, words follow
    assign dout = (state == st_unload && !done) ? rd_data0 : '0;

endmodule

/* design/ntt_twiddle_table.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// twiddle table
// holds w^0 .. w^(N/2-1) and the modulus, one registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ntt_params.svh"

module ntt_twiddle_table import ntt_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  ntt_state_t state,
    input  addr_t      count,
    input  coef_t      din,
    input  tw_addr_t   rd_addr,
    output coef_t      w,
    output coef_t      q_mod
);

    coef_t tw_mem [`NTT_N/2];

    always_ff @(posedge clk) begin
        if (state == st_load_tw && count < addr_t'(`NTT_N / 2))
            tw_mem[tw_addr_t'(count)] <= din;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w     <= '0;
            q_mod <= '0;
        end else begin
            w <= tw_mem[rd_addr];
            // modulus follows the last twiddle
            if (state == st_load_tw && count == addr_t'(`NTT_N / 2))
                q_mod <= din;
        end
    end

endmodule

/* design/pipe_delay.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipe delay
// fixed-length register delay line for any packed payload
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pipe_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic reset,
    input  T     d,
    output T     q
);

    T stages [DEPTH];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++)
                stages[i] <= '0;
        end else begin
            stages[0] <= d;
            for (int i = 1; i < DEPTH; i++)
                stages[i] <= stages[i-1];
        end
    end

    assign q = stages[DEPTH-1];

endmodule

/* ntt_lite.f */
+incdir+design
design/ntt_pkg.sv
design/pipe_delay.sv
design/ntt_butterfly.sv
design/ntt_coef_store.sv
design/ntt_twiddle_table.sv
design/ntt_ctrl_fsm.sv
design/ntt_stage_counter.sv
design/ntt_top.sv
verification/ntt_sva.sv
verification/ntt_tb.sv

/* verification/ntt_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt control assertions
// done pulse shape and its relation to accepted start commands
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ntt_params.svh"

module ntt_sva import ntt_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       load_w,
    input logic       load_data,
    input logic       start,
    input ntt_state_t state,
    input logic       done
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ISSUE = `NTT_N / 2;

    logic start_ok;
    logic seen_start;

    // count of failed assertions
    int fail_count = 0;

    // start only counts in idle and below the other two commands
    assign start_ok = start && !load_w && !load_data && (state == st_idle);

    // armed by an accepted start, used up by its done
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            seen_start <= 1'b0;
        else if (start_ok)
            seen_start <= 1'b1;
        else if (done)
            seen_start <= 1'b0;
    end

    done_single_cycle: assert property (
        @(posedge clk) disable iff (reset) done |=> !done
    ) else begin
        $error("done stayed high for more than one cycle");
        fail_count++;
    end

    done_after_start: assert property (
        @(posedge clk) disable iff (reset) done |-> seen_start
    ) else begin
        $error("done raised with no accepted start before it");
        fail_count++;
    end

    // first stage issue cycles can never end the transform
    no_early_done: assert property (
        @(posedge clk) disable iff (reset) start_ok |=> (!done) [*ISSUE]
    ) else begin
        $error("done raised during the first butterfly issue cycles");
        fail_count++;
    end

endmodule

bind ntt_top ntt_sva sva0 (
    .clk       (clk),
    .reset     (reset),
    .load_w    (load_w),
    .load_data (load_data),
    .start     (start),
    .state     (state),
    .done      (done)
);

/* verification/ntt_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ntt testbench
// random forward transforms checked against a direct O(N^2) model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ntt_params.svh"

module ntt_tb import ntt_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N              = `NTT_N;
    localparam int Q              = 7681;
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_TRANSFORMS = 8;
    localparam int DONE_LIMIT     = `NTT_LOG_N * (N / 2 + `NTT_DRAIN) + 10;
    // data load, compute, unload and a few stray commands
    localparam int TRANSFORM_CYCLES = (N + 3) + DONE_LIMIT + (N + 2) + 8;
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES + (N / 2 + 3) + 5
                                    + NUM_TRANSFORMS * TRANSFORM_CYCLES + 100;

    logic   clk;
    logic   reset;
    logic   load_w;
    logic   load_data;
    logic   start;
    coef_t  din;
    logic   done;
    coef_t  dout;

    integer seed;
    longint root;
    coef_t  coef_in  [N];
    coef_t  expected [N];
    int     checks;
    int     value_errors;
    int     protocol_errors;
    int     done_pulses;

    ntt_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .load_w    (load_w),
        .load_data (load_data),
        .start     (start),
        .din       (din),
        .done      (done),
        .dout      (dout)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (done === 1'b1)
            done_pulses++;
    end

    function automatic longint mod_pow(longint base, int exp);
        longint result;
        result = 1;
        for (int i = 0; i < exp; i++)
            result = (result * base) % Q;
        return result;
    endfunction

    function automatic int bit_reverse(int idx);
        int r;
        r = 0;
        for (int i = 0; i < `NTT_LOG_N; i++)
            r = (r << 1) | ((idx >> i) & 1);
        return r;
    endfunction

    // w^(N/2) = -1 means order exactly N
    function automatic longint find_root();
        for (longint c = 2; c < Q; c++) begin
            if (mod_pow(c, N / 2) == Q - 1)
                return c;
        end
        return 0;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] exp_val,
                               input string what);
        checks++;
        if (actual !== exp_val) begin
            value_errors++;
            $display("** Error at %0t: %s: got %0d, expected %0d",
                     $time, what, actual, exp_val);
        end
    endtask

    // direct transform, then bit-reversed output order
    task automatic build_expected();
        longint y [N];
        longint acc;
        for (int k = 0; k < N; k++) begin
            acc = 0;
            for (int j = 0; j < N; j++)
                acc = (acc + coef_in[j] * mod_pow(root, (j * k) % N)) % Q;
            y[k] = acc;
        end
        for (int i = 0; i < N; i++)
            expected[i] = coef_t'(y[bit_reverse(i)]);
    endtask

    task automatic random_case();
        for (int j = 0; j < N; j++)
            coef_in[j] = coef_t'($unsigned($random(seed)) % Q);
        build_expected();
    endtask

    task automatic load_twiddles();
        @(negedge clk);
        load_w = 1'b1;
        for (int i = 0; i <= N / 2; i++) begin
            @(negedge clk);
            load_w = 1'b0;
            // modulus follows the last twiddle
            din = (i < N / 2) ? coef_t'(mod_pow(root, i)) : coef_t'(Q);
        end
        @(negedge clk);
        din = '0;
    endtask

    task automatic load_coefs();
        @(negedge clk);
        load_data = 1'b1;
        for (int j = 0; j < N; j++) begin
            @(negedge clk);
            load_data = 1'b0;
            din = coef_in[j];
        end
        @(negedge clk);
        din = '0;
    endtask

    task automatic run_transform(input bit stray_commands, input string name);
        int pulses_before;
        int cycles;
        load_coefs();
        pulses_before = done_pulses;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (stray_commands) begin
            // all three land in compute and must be dropped
            repeat (3) @(negedge clk);
            load_w = 1'b1;
            @(negedge clk);
            load_w = 1'b0;
            load_data = 1'b1;
            @(negedge clk);
            load_data = 1'b0;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            protocol_errors++;
            $display("%s: done did not arrive within %0d cycles of start", name, DONE_LIMIT);
        end else begin
            for (int i = 0; i < N; i++) begin
                @(negedge clk);
                check_value(done, 1'b0, {name, ": done after its pulse"});
                check_value(dout, expected[i], $sformatf("%s: dout word %0d", name, i));
            end
            check_value(done_pulses - pulses_before, 1, {name, ": done pulses per start"});
        end
        @(negedge clk);
    endtask

    initial begin
        coef_t c;
        seed            = 32'hdec33d3f;
        checks          = 0;
        value_errors    = 0;
        protocol_errors = 0;
        done_pulses     = 0;
        reset           = 1'b1;
        load_w          = 1'b0;
        load_data       = 1'b0;
        start           = 1'b0;
        din             = '0;
        root            = find_root();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // quiet outputs before any command
        repeat (5) begin
            @(negedge clk);
            check_value(done, 1'b0, "done after reset");
            check_value(dout, '0, "dout after reset");
        end

        load_twiddles();
        random_case();
        run_transform(1'b0, "first transform");

        // twiddle table stays loaded
        for (int t = 0; t < 4; t++) begin
            random_case();
            run_transform(1'b0, $sformatf("back-to-back %0d", t));
        end

        for (int j = 0; j < N; j++) begin
            coef_in[j]  = '0;
            expected[j] = '0;
        end
        run_transform(1'b0, "all zero");

        // impulse at a0 spreads to every output
        c = coef_t'(1 + $unsigned($random(seed)) % (Q - 1));
        for (int j = 0; j < N; j++) begin
            coef_in[j]  = (j == 0) ? c : '0;
            expected[j] = c;
        end
        run_transform(1'b0, "impulse");

        random_case();
        run_transform(1'b1, "stray commands");

        $display("checks: %0d, value errors: %0d, protocol errors: %0d, assertion errors: %0d",
                 checks, value_errors, protocol_errors, dut0.sva0.fail_count);
        if (value_errors + protocol_errors + dut0.sva0.fail_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the tests finished",
                 WATCHDOG_CYCLES);
        $display("checks: %0d, value errors: %0d, protocol errors: %0d, assertion errors: %0d",
                 checks, value_errors, protocol_errors, dut0.sva0.fail_count);
        $display("Result: FAILED");
        $finish;
    end

endmodule
